/* design/cuPkg.sv */
package cuPkg;

    localparam int instrWidth = 32;
    localparam int flagWidth  = 4;
    localparam int condWidth  = 4;
    localparam int stateWidth = 5;

    typedef logic [instrWidth-1:0] instr_t;
    typedef logic [flagWidth-1:0]  flags_t;   // N Z C V with N in the msb
    typedef logic [condWidth-1:0]  cond_t;    // Instruction bits 31:28

    // Microstates with the fetch entry pinned at zero
    typedef enum logic [stateWidth-1:0] {
        Fetch0     = 5'd0,
        Fetch1     = 5'd1,
        Fetch2     = 5'd2,
        Decode     = 5'd3,
        DpReg,
        DpShift,
        DpImm,
        TestReg,
        TestShift,
        TestImm,
        BranchLink,
        Branch,                                // Must follow BranchLink
        LdrImm,
        LdrReg,
        LdrMem,
        LdrWb,                                 // Must follow LdrMem
        StrImm,
        StrReg,
        StrData,
        StrMem
    } uState_t;

    // Next-address modes of the sequencer
    typedef enum logic [2:0] {
        encoder                 = 3'b000,
        fetch                   = 3'b001,
        target                  = 3'b010,
        increment               = 3'b011,
        stsTargetElseEncoder    = 3'b100,
        stsTargetElseIncrement  = 3'b101,
        stsEncoderElseIncrement = 3'b110,
        stsTargetElseFetch      = 3'b111
    } nextMode_t;

    typedef enum logic {
        stsMoc  = 1'b0,
        stsCond = 1'b1
    } stsSel_t;

    typedef enum logic [3:0] {
        opPass      = 4'd0,                    // A operand straight through
        opAdd       = 4'd1,
        opAdd4      = 4'd2,                    // PC + 4
        opSub       = 4'd3,
        opFromInstr = 4'd4                     // ALU decodes the opcode field
    } aluOp_t;

    typedef enum logic [1:0] {
        bReg   = 2'd0,
        bShift = 2'd1,
        bImm   = 2'd2,
        bMdr   = 2'd3
    } aluBSel_t;

    typedef struct packed {
        logic     rfLoad;
        logic     irLoad;
        logic     marLoad;
        logic     mdrLoad;
        logic     srLoad;
        logic     mov;                         // Memory request held until moc
        logic     rw;                          // 1 = read
        logic     aluASelPc;
        aluBSel_t aluBSel;
        aluOp_t   aluOp;
    } ctrlWord_t;

    typedef struct packed {
        ctrlWord_t ctrl;
        nextMode_t nextMode;
        stsSel_t   stsSel;
        logic      stsInv;
        uState_t   target;
    } microWord_t;

endpackage

/* design/instrDecoder.sv */
module instrDecoder import cuPkg::*; (
    input  instr_t  instr,
    output uState_t entryState
);

    logic isTest;     // TST/TEQ/CMP/CMN without register write
    logic isRegForm;  // Bit 4 of a class 000 data op
    logic isOffset;   // P set and W clear
    logic isLoad;
    logic isRegOff;   // Class 011 carries a register offset

    assign isTest    = instr[24] && !instr[23];
    assign isRegForm = instr[4];
    assign isOffset  = instr[24] && !instr[21];
    assign isLoad    = instr[20];
    assign isRegOff  = instr[25];

    always_comb begin
        case (instr[27:25])
            3'b000: begin  // Data processing with register or immediate shift
                if (isTest) begin
                    entryState = isRegForm ? TestReg : TestShift;
                end else begin
                    entryState = isRegForm ? DpReg : DpShift;
                end
            end
            3'b001: begin
                entryState = isTest ? TestImm : DpImm;
            end
            3'b010, 3'b011: begin
                // Pre and post indexed forms are not executed
                if (!isOffset) begin
                    entryState = Fetch0;
                end else if (isLoad) begin
                    entryState = isRegOff ? LdrReg : LdrImm;
                end else begin
                    entryState = isRegOff ? StrReg : StrImm;
                end
            end
            3'b101: begin
                entryState = instr[24] ? BranchLink : Branch;  // L bit
            end
            default: begin
                entryState = Fetch0;  // Unknown class
            end
        endcase
    end

endmodule

/* design/condEval.sv */
module condEval import cuPkg::*; (
    input  cond_t  cond,
    input  flags_t flags,
    output logic   condPass
);

    logic n;
    logic z;
    logic c;
    logic v;

    assign n = flags[3];
    assign z = flags[2];
    assign c = flags[1];
    assign v = flags[0];

    always_comb begin
        case (cond)
            4'h0:    condPass = z;                 // EQ
            4'h1:    condPass = !z;                // NE
            4'h2:    condPass = c;                 // CS/HS
            4'h3:    condPass = !c;                // CC/LO
            4'h4:    condPass = n;                 // MI
            4'h5:    condPass = !n;                // PL
            4'h6:    condPass = v;                 // VS
            4'h7:    condPass = !v;                // VC
            4'h8:    condPass = c && !z;           // HI
            4'h9:    condPass = !c || z;           // LS
            4'hA:    condPass = (n == v);          // GE
            4'hB:    condPass = (n != v);          // LT
            4'hC:    condPass = !z && (n == v);    // GT
            4'hD:    condPass = z || (n != v);     // LE
            4'hE:    condPass = 1'b1;              // AL
            default: condPass = 1'b0;              // 1111 never executes here
        endcase
    end

endmodule

/* design/microStore.sv */
module microStore import cuPkg::*; (
    input  uState_t    state,
    output microWord_t word
);

    aluBSel_t execBSel;  // B operand of the execute states

    always_comb begin
        case (state)
            DpShift, TestShift:                     execBSel = bShift;
            DpImm, TestImm, LdrImm, StrImm, Branch: execBSel = bImm;
            default:                                execBSel = bReg;
        endcase
    end

    always_comb begin
        word          = '0;      // Idle controls, bReg, opPass, status moc
        word.nextMode = fetch;
        word.target   = Fetch0;
        case (state)
            Fetch1: begin
                word.ctrl.mov     = 1'b1;
                word.ctrl.rw      = 1'b1;
                word.ctrl.mdrLoad = 1'b1;
                word.nextMode     = stsTargetElseIncrement;
                word.stsInv       = 1'b1;  // Loop while moc is low
                word.target       = Fetch1;
            end
            Fetch2: begin
                word.ctrl.irLoad    = 1'b1;
                word.ctrl.rfLoad    = 1'b1;  // PC update
                word.ctrl.aluASelPc = 1'b1;
                word.ctrl.aluOp     = opAdd4;
                word.nextMode       = increment;
            end
            Decode: begin
                word.nextMode = stsTargetElseEncoder;
                word.stsSel   = stsCond;
                word.stsInv   = 1'b1;        // Failed condition back to Fetch0
            end
            DpReg, DpShift, DpImm: begin
                word.ctrl.rfLoad  = 1'b1;
                word.ctrl.srLoad  = 1'b1;
                word.ctrl.aluBSel = execBSel;
                word.ctrl.aluOp   = opFromInstr;
            end
            TestReg, TestShift, TestImm: begin
                word.ctrl.srLoad  = 1'b1;    // Flags only
                word.ctrl.aluBSel = execBSel;
                word.ctrl.aluOp   = opFromInstr;
            end
            BranchLink: begin
                word.ctrl.rfLoad    = 1'b1;  // LR gets the PC
                word.ctrl.aluASelPc = 1'b1;
                word.nextMode       = increment;
            end
            Branch: begin
                word.ctrl.rfLoad    = 1'b1;
                word.ctrl.aluASelPc = 1'b1;
                word.ctrl.aluBSel   = execBSel;
                word.ctrl.aluOp     = opAdd;
            end
            LdrImm, LdrReg, StrImm, StrReg: begin
                word.ctrl.marLoad = 1'b1;    // Base plus offset
                word.ctrl.aluBSel = execBSel;
                word.ctrl.aluOp   = opAdd;
                word.nextMode     = target;
                word.target       = (state inside {LdrImm, LdrReg}) ? LdrMem : StrData;
            end
            LdrMem: begin
                word.ctrl.mov     = 1'b1;
                word.ctrl.rw      = 1'b1;
                word.ctrl.mdrLoad = 1'b1;
                word.nextMode     = stsTargetElseIncrement;
                word.stsInv       = 1'b1;
                word.target       = LdrMem;
            end
            LdrWb: begin
                word.ctrl.rfLoad  = 1'b1;
                word.ctrl.aluBSel = bMdr;
            end
            StrData: begin
                word.ctrl.mdrLoad = 1'b1;    // Rd into MDR
                word.nextMode     = increment;
            end
            StrMem: begin
                word.ctrl.mov = 1'b1;        // rw stays low for a write
                word.nextMode = stsTargetElseFetch;
                word.stsInv   = 1'b1;
                word.target   = StrMem;
            end
            default: begin                   // Fetch0 and unused addresses
                word.ctrl.marLoad   = 1'b1;
                word.ctrl.aluASelPc = 1'b1;
                word.nextMode       = increment;
            end
        endcase
    end

    // A memory cycle must never latch the IR in the same state
    always_comb begin
        movIrExclusive: assert final (!(word.ctrl.mov && word.ctrl.irLoad))
            else $error("microStore: mov and irLoad both set in state %0d", state);
    end

endmodule

/* design/microSequencer.sv */
module microSequencer import cuPkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  microWord_t word,
    input  uState_t    entryState,
    input  logic       condPass,
    input  logic       moc,
    output uState_t    state
);

    typedef enum logic [1:0] {
        srcEncoder   = 2'b00,
        srcFetch     = 2'b01,
        srcTarget    = 2'b10,
        srcIncrement = 2'b11
    } addrSrc_t;

    logic     stsRaw;
    logic     sts;
    addrSrc_t addrSrc;
    uState_t  incState;
    uState_t  nextState;

    assign stsRaw   = (word.stsSel == stsCond) ? condPass : moc;
    assign sts      = stsRaw ^ word.stsInv;  // Optional inversion
    assign incState = uState_t'(state + stateWidth'(1));

    // Eight modes down to four address sources
    always_comb begin
        case (word.nextMode)
            encoder:                 addrSrc = srcEncoder;
            fetch:                   addrSrc = srcFetch;
            target:                  addrSrc = srcTarget;
            increment:               addrSrc = srcIncrement;
            stsTargetElseEncoder:    addrSrc = sts ? srcTarget : srcEncoder;
            stsTargetElseIncrement:  addrSrc = sts ? srcTarget : srcIncrement;
            stsEncoderElseIncrement: addrSrc = sts ? srcEncoder : srcIncrement;
            stsTargetElseFetch:      addrSrc = sts ? srcTarget : srcFetch;
            default:                 addrSrc = srcFetch;
        endcase
    end

    always_comb begin
        case (addrSrc)
            srcEncoder: nextState = entryState;
            srcFetch:   nextState = Fetch0;
            srcTarget:  nextState = word.target;
            default:    nextState = incState;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= Fetch0;
        end else begin
            state <= nextState;
        end
    end

    // Incrementer or target must not run past the last microstate
    stateLegal: assert property (
        @(posedge clk) disable iff (!rstN)
        state inside {[Fetch0:StrMem]}
    ) else $error("microSequencer: illegal state %0d", state);

    // Wait states hold until memory answers
    holdOnWait: assert property (
        @(posedge clk) disable iff (!rstN)
        (word.ctrl.mov && !moc) |=> $stable(state)
    ) else $error("microSequencer: left wait state without moc");

    resetToFetch: assert property (
        @(posedge clk)
        !rstN |=> (state == Fetch0)
    ) else $error("microSequencer: state not Fetch0 after reset");

endmodule

/* design/controlUnit.sv */
module controlUnit import cuPkg::*; (
    input  logic      clk,
    input  logic      rstN,
    input  instr_t    instr,     // Held from Fetch2 to instruction end
    input  flags_t    flags,
    input  logic      moc,
    output ctrlWord_t ctrl,
    output uState_t   uState
);

    microWord_t word;
    uState_t    entryState;
    logic       condPass;

    microSequencer seq0 (
        .clk        (clk),
        .rstN       (rstN),
        .word       (word),
        .entryState (entryState),
        .condPass   (condPass),
        .moc        (moc),
        .state      (uState)
    );

    microStore store0 (
        .state (uState),
        .word  (word)
    );

    instrDecoder dec0 (
        .instr      (instr),
        .entryState (entryState)
    );

    condEval cond0 (
        .cond     (instr[31:28]),
        .flags    (flags),
        .condPass (condPass)
    );

    assign ctrl = word.ctrl;  // Datapath controls of the current microword

endmodule

/* tb/tbModel.svh */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

logic [31:0] lfsrState = 32'h2204_558e;  // Fixed seed

// Fibonacci LFSR with taps 32 22 2 1 and one step per bit returned
function automatic logic [31:0] randBits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int k = 0; k < n; k++) begin
        fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], fb};
        r = {r[30:0], fb};
    end
    return r;
endfunction

// ARM pairs each test with its inverse in cond[0]
function automatic logic expCondPass(input cond_t c, input flags_t f);
    logic base;
    case (c[3:1])
        3'd0:    base = f[2];                          // EQ
        3'd1:    base = f[1];                          // CS
        3'd2:    base = f[3];                          // MI
        3'd3:    base = f[0];                          // VS
        3'd4:    base = f[1] & ~f[2];                  // HI
        3'd5:    base = ~(f[3] ^ f[0]);                // GE
        3'd6:    base = ~f[2] & ~(f[3] ^ f[0]);        // GT
        default: base = 1'b1;                          // AL while 1111 inverts to fail
    endcase
    return c[0] ? ~base : base;
endfunction

function automatic uState_t expEntryState(input instr_t i);
    logic test;
    test = i[24] & ~i[23];
    case (i[27:25])
        3'b000:  return i[4] ? (test ? TestReg : DpReg) : (test ? TestShift : DpShift);
        3'b001:  return test ? TestImm : DpImm;
        3'b010:  return (!i[24] || i[21]) ? Fetch0 : (i[20] ? LdrImm : StrImm);
        3'b011:  return (!i[24] || i[21]) ? Fetch0 : (i[20] ? LdrReg : StrReg);
        3'b101:  return i[24] ? BranchLink : Branch;
        default: return Fetch0;
    endcase
endfunction

function automatic uState_t expNextState(input uState_t s, input logic mocIn,
                                         input logic condOk, input uState_t entry);
    case (s)
        Fetch0:         return Fetch1;
        Fetch1:         return mocIn ? Fetch2 : Fetch1;
        Fetch2:         return Decode;
        Decode:         return condOk ? entry : Fetch0;
        BranchLink:     return Branch;
        LdrImm, LdrReg: return LdrMem;
        LdrMem:         return mocIn ? LdrWb : LdrMem;
        StrImm, StrReg: return StrData;
        StrData:        return StrMem;
        StrMem:         return mocIn ? Fetch0 : StrMem;
        default:        return Fetch0;             // Single-cycle execute states
    endcase
endfunction

// Cycles from Fetch0 back to Fetch0 without moc stalls
function automatic int expLength(input uState_t entry, input logic condOk);
    if (!condOk) begin
        return 4;
    end
    case (entry)
        Fetch0:                         return 4;
        BranchLink:                     return 6;
        LdrImm, LdrReg, StrImm, StrReg: return 7;
        default:                        return 5;
    endcase
endfunction

`endif

/* tb/tbTop.sv */
module tbTop import cuPkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    logic      clk;
    logic      rstN;
    instr_t    instr;
    flags_t    flags;
    logic      moc;
    ctrlWord_t ctrl;
    uState_t   uState;

    int checks = 0;
    int errors = 0;

    // One instruction per executed form with condition AL
    instr_t execList [12] = '{
        32'hE081_0012, 32'hE081_0002, 32'hE281_0001,  // DP reg, shift, imm
        32'hE151_0012, 32'hE151_0002, 32'hE351_0001,  // CMP reg, shift, imm
        32'hEA00_0004, 32'hEB00_0004,                 // B, BL
        32'hE591_0004, 32'hE791_0002,                 // LDR imm, reg
        32'hE581_0004, 32'hE781_0002                  // STR imm, reg
    };

    `include "tbModel.svh"

    controlUnit dut0 (
        .clk    (clk),
        .rstN   (rstN),
        .instr  (instr),
        .flags  (flags),
        .moc    (moc),
        .ctrl   (ctrl),
        .uState (uState)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic expectEq(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    // Controls that the microprogram table fixes per state
    task automatic verifyCtrl(input uState_t s);
        case (s)
            Fetch0: begin
                expectEq("ctrl.marLoad", ctrl.marLoad, 1'b1);
                expectEq("ctrl.mov", ctrl.mov, 1'b0);
                expectEq("ctrl.aluASelPc", ctrl.aluASelPc, 1'b1);
            end
            Fetch1, LdrMem: begin
                expectEq("ctrl.mov", ctrl.mov, 1'b1);
                expectEq("ctrl.rw", ctrl.rw, 1'b1);
                expectEq("ctrl.mdrLoad", ctrl.mdrLoad, 1'b1);
            end
            Fetch2: begin
                expectEq("ctrl.irLoad", ctrl.irLoad, 1'b1);
                expectEq("ctrl.aluOp", ctrl.aluOp, opAdd4);
            end
            DpReg, DpShift, DpImm: begin
                expectEq("ctrl.rfLoad", ctrl.rfLoad, 1'b1);
                expectEq("ctrl.srLoad", ctrl.srLoad, 1'b1);
            end
            TestReg, TestShift, TestImm: begin
                expectEq("ctrl.srLoad", ctrl.srLoad, 1'b1);
                expectEq("ctrl.rfLoad", ctrl.rfLoad, 1'b0);  // Flags only
            end
            Branch: begin
                expectEq("ctrl.aluBSel", ctrl.aluBSel, bImm);
                expectEq("ctrl.aluOp", ctrl.aluOp, opAdd);
            end
            LdrWb: begin
                expectEq("ctrl.rfLoad", ctrl.rfLoad, 1'b1);
                expectEq("ctrl.aluBSel", ctrl.aluBSel, bMdr);
            end
            StrData:               expectEq("ctrl.mdrLoad", ctrl.mdrLoad, 1'b1);
            StrMem: begin
                expectEq("ctrl.mov", ctrl.mov, 1'b1);
                expectEq("ctrl.rw", ctrl.rw, 1'b0);
            end
            default: ;
        endcase
    endtask

    // Starts and ends at a falling edge with the DUT in Fetch0
    task automatic runInstr(input instr_t ins, input flags_t fl, input int forceDelay);
        uState_t expState;
        uState_t entry;
        logic    condOk;
        int      cycles;
        int      stalls;
        int      waitCnt;
        int      delay;
        logic    done;
        instr    = ins;
        flags    = fl;
        condOk   = expCondPass(ins[31:28], fl);
        entry    = expEntryState(ins);
        expState = Fetch0;
        cycles   = 0;
        stalls   = 0;
        waitCnt  = 0;
        delay    = 0;
        done     = 1'b0;
        while (!done && cycles < 50) begin
            expectEq("uState", uState, expState);
            verifyCtrl(expState);
            if (expState inside {Fetch1, LdrMem, StrMem}) begin
                if (waitCnt == 0) begin
                    delay = (forceDelay >= 0) ? forceDelay : int'(randBits(2));
                end
                moc = (waitCnt == delay);   // Memory answers after the delay
                waitCnt = moc ? 0 : waitCnt + 1;
                if (!moc) begin
                    stalls++;
                end
            end else begin
                moc = 1'b0;
            end
            expState = expNextState(expState, moc, condOk, entry);
            cycles++;
            @(negedge clk);
            done = (uState == Fetch0);
        end
        moc = 1'b0;
        if (!done) begin
            errors++;
            $display("Timeout: instruction 0x%08h did not return to Fetch0 in 50 cycles", ins);
        end else begin
            expectEq("uState", uState, expState);
            expectEq("cycles", cycles - stalls, expLength(entry, condOk));
        end
    endtask

    task automatic finishTest(input string name, input int errBefore);
        $display("%s finished with %0d errors", name, errors - errBefore);
    endtask

    initial begin
        logic [31:0] rnd;
        int          errBefore;
        rstN  = 1'b0;
        instr = '0;
        flags = '0;
        moc   = 1'b0;

        errBefore = errors;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        expectEq("uState", uState, Fetch0);
        expectEq("ctrl.marLoad", ctrl.marLoad, 1'b1);
        expectEq("ctrl.mov", ctrl.mov, 1'b0);
        expectEq("ctrl.irLoad", ctrl.irLoad, 1'b0);
        expectEq("ctrl.rfLoad", ctrl.rfLoad, 1'b0);
        finishTest("reset", errBefore);

        errBefore = errors;
        runInstr(32'hE081_0002, 4'h0, 3);  // Three low moc cycles in each wait
        runInstr(32'hE591_0004, 4'h0, 0);
        finishTest("fetch handshake", errBefore);

        errBefore = errors;
        for (int k = 0; k < 200; k++) begin
            rnd = randBits(32);
            runInstr(rnd, flags_t'(randBits(4)), -1);
        end
        finishTest("condition", errBefore);

        errBefore = errors;
        for (int cls = 0; cls < 8; cls++) begin
            for (int k = 0; k < 8; k++) begin
                rnd = randBits(25);
                runInstr({4'hE, 3'(cls), rnd[24:0]}, flags_t'(randBits(4)), -1);
            end
        end
        finishTest("decoding", errBefore);

        errBefore = errors;
        foreach (execList[k]) begin
            runInstr(execList[k], flags_t'(randBits(4)), -1);
        end
        finishTest("execution sequences", errBefore);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+tb
design/cuPkg.sv
design/instrDecoder.sv
design/condEval.sv
design/microStore.sv
design/microSequencer.sv
design/controlUnit.sv
tb/tbTop.sv
